// ==== source/mac_table_pkg.sv ====
package mac_table_pkg;

  // ==========================================================================
  // widths and table size
  // ==========================================================================

  localparam int MAC_W       = 48;
  localparam int PORTMAP_W   = 16;
  localparam int INDEX_W     = 10;
  localparam int TABLE_DEPTH = 1024;

  // size of one stored entry, portmap plus mac
  localparam int ENTRY_W     = 64;

  typedef logic [MAC_W-1:0]     mac_t;
  typedef logic [PORTMAP_W-1:0] portmap_t;
  typedef logic [INDEX_W-1:0]   index_t;

  // ==========================================================================
  // stored data
  // ==========================================================================

  // portmap sits in the upper 16 bits, mac below it
  typedef struct packed {
    portmap_t portmap;
    mac_t     mac;
  } mac_entry_t;

  // tag word, only the valid flag is left
  typedef struct packed {
    logic valid;
  } tag_t;

  // ==========================================================================
  // request and way traffic
  // ==========================================================================

  typedef struct packed {
    logic     source;     // 1 = learn, 0 = lookup
    mac_t     mac;
    portmap_t portmap;
    index_t   index;      // bucket, hashed by the caller
  } table_req_t;

  // answer of one way for the current bucket
  typedef struct packed {
    logic     valid;
    logic     hit;
    portmap_t portmap;
  } way_result_t;

  // write into one way, used by write-back and flush
  typedef struct packed {
    index_t     index;
    tag_t       tag;
    mac_entry_t entry;
  } way_write_t;

endpackage

// ==== source/mac_table_ram.sv ====
`timescale 1ns/1ps

// single-port synchronous store, stands in for a vendor block RAM
module mac_table_ram #(
  parameter type word_t = logic,
  parameter int  DEPTH  = mac_table_pkg::TABLE_DEPTH
) (
  input  logic                  clk,
  input  logic                  en,
  input  logic                  wr,
  input  mac_table_pkg::index_t addr,
  input  word_t                 din,
  output word_t                 dout
);

  // ==========================================================================
  // storage
  // ==========================================================================

  word_t mem [DEPTH];

  // read-first: on a write the old word comes out
  always_ff @(posedge clk) begin
    if (en) begin
      if (wr) begin
        mem[addr] <= din;
      end
      dout <= mem[addr];
    end
  end

endmodule

// ==== source/mac_table_way.sv ====
`timescale 1ns/1ps

module mac_table_way (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       lookup,
  input  mac_table_pkg::index_t      lookup_index,
  input  mac_table_pkg::mac_t        lookup_mac,
  input  logic                       wr,
  input  mac_table_pkg::way_write_t  wr_data,
  output mac_table_pkg::way_result_t result
);
  import mac_table_pkg::*;

  logic       ram_en;
  index_t     ram_addr;
  tag_t       tag_rd;
  mac_entry_t entry_rd;

  // pipeline strobes following a lookup
  logic       rd_q;
  logic       cmp_q;

  // first compare stage
  logic       valid_q;
  logic       lo_match_q;
  logic       hi_match_q;
  portmap_t   portmap_q;

  // ==========================================================================
  // stores
  // ==========================================================================

  assign ram_en   = lookup | wr;
  assign ram_addr = lookup ? lookup_index : wr_data.index;

  mac_table_ram #(
    .word_t (tag_t),
    .DEPTH  (TABLE_DEPTH)
  ) u_tag_ram (
    .clk  (clk),
    .en   (ram_en),
    .wr   (wr),
    .addr (ram_addr),
    .din  (wr_data.tag),
    .dout (tag_rd)
  );

  mac_table_ram #(
    .word_t (mac_entry_t),
    .DEPTH  (TABLE_DEPTH)
  ) u_entry_ram (
    .clk  (clk),
    .en   (ram_en),
    .wr   (wr),
    .addr (ram_addr),
    .din  (wr_data.entry),
    .dout (entry_rd)
  );

  // ==========================================================================
  // match pipeline
  // ==========================================================================

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_q  <= 1'b0;
      cmp_q <= 1'b0;
    end else begin
      rd_q  <= lookup;
      cmp_q <= rd_q;
    end
  end

  // mac compared as two 24-bit halves, joined a cycle later
  always_ff @(posedge clk) begin
    if (rd_q) begin
      valid_q    <= tag_rd.valid;
      lo_match_q <= (entry_rd.mac[MAC_W/2-1:0] == lookup_mac[MAC_W/2-1:0]);
      hi_match_q <= (entry_rd.mac[MAC_W-1:MAC_W/2] == lookup_mac[MAC_W-1:MAC_W/2]);
      portmap_q  <= entry_rd.portmap;
    end
  end

  // held until the next lookup
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      result <= '0;
    end else if (cmp_q) begin
      result.valid   <= valid_q;
      result.hit     <= valid_q & lo_match_q & hi_match_q;
      result.portmap <= portmap_q;
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================

  initial begin
    assert ($bits(mac_entry_t) == ENTRY_W)
      else $fatal(1, "mac_entry_t is %0d bits, expected %0d", $bits(mac_entry_t), ENTRY_W);
  end

  // the controller must keep write-back and flush off the lookup cycle
  assert property (@(posedge clk) disable iff (!rstn) !(lookup && wr))
    else $error("lookup and write in the same cycle");

endmodule

// ==== source/mac_table_ctrl.sv ====
`timescale 1ns/1ps

module mac_table_ctrl (
  input  logic                       clk,
  input  logic                       rstn,
  input  mac_table_pkg::table_req_t  req,
  input  logic                       req_valid,
  input  mac_table_pkg::way_result_t way0_res,
  input  mac_table_pkg::way_result_t way1_res,
  output logic                       lookup,
  output mac_table_pkg::index_t      lookup_index,
  output mac_table_pkg::mac_t        lookup_mac,
  output logic                       way0_wr,
  output logic                       way1_wr,
  output mac_table_pkg::way_write_t  way_wr_data,
  output logic                       ready,
  output logic                       ack,
  output logic                       nak,
  output mac_table_pkg::portmap_t    result
);
  import mac_table_pkg::*;

  typedef enum logic [2:0] {
    ST_FLUSH,
    ST_IDLE,
    ST_READ,
    ST_COMPARE,
    ST_RESPOND
  } state_t;

  state_t     state;
  table_req_t req_q;
  index_t     flush_idx;

  // way choice for the respond state
  logic       found;
  portmap_t   found_portmap;
  logic       pick_way0;
  logic       pick_way1;

  // ==========================================================================
  // lookup side
  // ==========================================================================

  // read starts on the accepting edge
  assign lookup       = ready & req_valid;
  assign lookup_index = req.index;
  assign lookup_mac   = req_q.mac;

  // way 0 wins a double hit for lookup and refresh alike
  always_comb begin
    found         = way0_res.hit | way1_res.hit;
    found_portmap = way0_res.hit ? way0_res.portmap : way1_res.portmap;
    // hit way first and then the first free way
    pick_way0     = way0_res.hit | (!way1_res.hit & !way0_res.valid);
    pick_way1     = !pick_way0 & (way1_res.hit | !way1_res.valid);
  end

  // ==========================================================================
  // sequencer
  // ==========================================================================

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= ST_FLUSH;
      flush_idx <= '0;
      ready     <= 1'b0;
      ack       <= 1'b0;
      nak       <= 1'b0;
      result    <= '0;
      way0_wr   <= 1'b0;
      way1_wr   <= 1'b0;
    end else begin
      ack     <= 1'b0;
      nak     <= 1'b0;
      way0_wr <= 1'b0;
      way1_wr <= 1'b0;
      case (state)
        // clear one bucket of both ways per cycle
        ST_FLUSH: begin
          way0_wr   <= 1'b1;
          way1_wr   <= 1'b1;
          flush_idx <= flush_idx + 1'b1;
          if (flush_idx == index_t'(TABLE_DEPTH - 1)) begin
            state <= ST_IDLE;
          end
        end
        // ready returns the cycle after the response
        ST_IDLE: begin
          if (lookup) begin
            ready <= 1'b0;
            state <= ST_READ;
          end else begin
            ready <= 1'b1;
          end
        end
        ST_READ: begin
          state <= ST_COMPARE;
        end
        ST_COMPARE: begin
          state <= ST_RESPOND;
        end
        ST_RESPOND: begin
          state <= ST_IDLE;
          if (req_q.source) begin
            // a learn naks only when the bucket is full
            ack     <= pick_way0 | pick_way1;
            nak     <= !(pick_way0 | pick_way1);
            way0_wr <= pick_way0;
            way1_wr <= pick_way1;
            result  <= req_q.portmap;
          end else begin
            // miss floods to every port but the ingress map
            ack    <= found;
            nak    <= !found;
            result <= found ? found_portmap : ~req_q.portmap;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // request copy and write payload
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && lookup) begin
      req_q <= req;
    end
    if (state == ST_FLUSH) begin
      way_wr_data <= '{index: flush_idx, tag: '{valid: 1'b0}, entry: '0};
    end else if (state == ST_RESPOND) begin
      way_wr_data <= '{index: req_q.index,
                       tag:   '{valid: 1'b1},
                       entry: '{portmap: req_q.portmap, mac: req_q.mac}};
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================

  assert property (@(posedge clk) disable iff (!rstn) !(ack && nak))
    else $error("ack and nak together");

  // only the flush writes both ways at once
  assert property (@(posedge clk) disable iff (!rstn)
    (way0_wr && way1_wr) |-> !way_wr_data.tag.valid)
    else $error("valid entry written into both ways");

  // the ways read on every accepted request, so only idle may accept one
  assert property (@(posedge clk) disable iff (!rstn)
    ready |-> (state == ST_IDLE))
    else $error("ready high outside the idle state");

endmodule

// ==== source/mac_table_top.sv ====
`timescale 1ns/1ps

module mac_table_top (
  input  logic                      clk,
  input  logic                      rstn,
  input  mac_table_pkg::table_req_t req,
  input  logic                      req_valid,
  output logic                      ready,
  output logic                      ack,
  output logic                      nak,
  output mac_table_pkg::portmap_t   result
);
  import mac_table_pkg::*;

  // ==========================================================================
  // controller to ways
  // ==========================================================================

  logic        lookup;
  index_t      lookup_index;
  mac_t        lookup_mac;
  logic        way0_wr;
  logic        way1_wr;
  way_write_t  way_wr_data;
  way_result_t way0_res;
  way_result_t way1_res;

  // two ways searched side by side
  mac_table_way u_way0 (
    .clk          (clk),
    .rstn         (rstn),
    .lookup       (lookup),
    .lookup_index (lookup_index),
    .lookup_mac   (lookup_mac),
    .wr           (way0_wr),
    .wr_data      (way_wr_data),
    .result       (way0_res)
  );

  mac_table_way u_way1 (
    .clk          (clk),
    .rstn         (rstn),
    .lookup       (lookup),
    .lookup_index (lookup_index),
    .lookup_mac   (lookup_mac),
    .wr           (way1_wr),
    .wr_data      (way_wr_data),
    .result       (way1_res)
  );

  mac_table_ctrl u_ctrl (
    .clk          (clk),
    .rstn         (rstn),
    .req          (req),
    .req_valid    (req_valid),
    .way0_res     (way0_res),
    .way1_res     (way1_res),
    .lookup       (lookup),
    .lookup_index (lookup_index),
    .lookup_mac   (lookup_mac),
    .way0_wr      (way0_wr),
    .way1_wr      (way1_wr),
    .way_wr_data  (way_wr_data),
    .ready        (ready),
    .ack          (ack),
    .nak          (nak),
    .result       (result)
  );

endmodule

// ==== tb/mac_table_tb.sv ====
`timescale 1ns/1ps

module mac_table_tb;
  import mac_table_pkg::*;

  // ==========================================================================
  // run limits and vector layout
  // ==========================================================================

  localparam int CLK_PERIOD    = 100;
  localparam int NUM_COLS      = 7;
  localparam int MAX_VECS      = 64;
  // flush sweep plus some slack
  localparam int READY_LIMIT   = TABLE_DEPTH + 32;
  localparam int RESP_LATENCY  = 3;
  localparam int RESP_LIMIT    = 8;
  // idle gap, ready wait, request latency and strobe check
  localparam int WORST_SPACING = 16;

  logic       clk;
  logic       rstn;
  table_req_t req;
  logic       req_valid;
  logic       ready;
  logic       ack;
  logic       nak;
  portmap_t   result;

  // per vector test, source, index, mac, portmap, exp_ack and exp_result
  logic [63:0] vec_mem [NUM_COLS*MAX_VECS];
  int          num_vecs;
  int          pass_count;
  int          fail_count;

  mac_table_top dut (
    .clk       (clk),
    .rstn      (rstn),
    .req       (req),
    .req_valid (req_valid),
    .ready     (ready),
    .ack       (ack),
    .nak       (nak),
    .result    (result)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  // ==========================================================================
  // helpers
  // ==========================================================================

  task automatic run_watchdog(input int limit);
    repeat (limit) @(posedge clk);
    $display("watchdog expired, run did not finish within %0d cycles", limit);
    $display("** FAIL **");
    $finish;
  endtask

  // outputs are sampled on the falling edge
  task automatic wait_ready(output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < READY_LIMIT) begin
      @(negedge clk);
      if (ready === 1'b1) begin
        ok = 1'b1;
      end else begin
        n++;
      end
    end
  endtask

  // latency counts edges after the sampling edge
  task automatic wait_response(output int latency, output bit seen);
    seen    = 1'b0;
    latency = 0;
    while (!seen && latency < RESP_LIMIT) begin
      @(negedge clk);
      latency++;
      if (ack === 1'b1 || nak === 1'b1) begin
        seen = 1'b1;
      end
    end
  endtask

  // ==========================================================================
  // stimulus and checks
  // ==========================================================================

  initial begin
    int unsigned seed;
    int          gap;
    int          latency;
    int          base;
    int          test_num;
    bit          seen;
    bit          ok;
    bit          test_ok;
    logic        exp_ack;
    portmap_t    exp_result;

    rstn       = 1'b0;
    req        = '0;
    req_valid  = 1'b0;
    num_vecs   = 0;
    pass_count = 0;
    fail_count = 0;
    seed       = $urandom(73187);

    $readmemh("tb/mac_table_golden.txt", vec_mem);
    // vector list ends at the first unset or zero test number
    while (num_vecs < MAX_VECS && !$isunknown(vec_mem[num_vecs*NUM_COLS])
           && vec_mem[num_vecs*NUM_COLS] != 0) begin
      num_vecs++;
    end
    if (num_vecs == 0) begin
      $display("no test vectors could be read from tb/mac_table_golden.txt");
      fail_count++;
    end

    fork
      run_watchdog(READY_LIMIT + num_vecs * WORST_SPACING + 200);
    join_none

    repeat (2) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    for (int i = 0; i < num_vecs; i++) begin
      base       = i * NUM_COLS;
      test_num   = int'(vec_mem[base]);
      exp_ack    = vec_mem[base+5][0];
      exp_result = vec_mem[base+6][PORTMAP_W-1:0];
      test_ok    = 1'b1;

      wait_ready(ok);
      if (!ok) begin
        $display("test %0d: ready never rose within %0d cycles", test_num, READY_LIMIT);
        fail_count++;
        break;
      end
      gap = $urandom_range(3, 0);
      repeat (gap) @(negedge clk);

      // one-cycle request strobe
      req.source  = vec_mem[base+1][0];
      req.index   = vec_mem[base+2][INDEX_W-1:0];
      req.mac     = vec_mem[base+3][MAC_W-1:0];
      req.portmap = vec_mem[base+4][PORTMAP_W-1:0];
      req_valid   = 1'b1;
      @(negedge clk);
      req_valid   = 1'b0;

      // ready falls on the accepting edge
      if (ready !== 1'b0) begin
        $display("Mismatch test %0d: ready expected %h actual %h", test_num, 1'b0, ready);
        test_ok = 1'b0;
      end

      wait_response(latency, seen);
      if (!seen) begin
        $display("test %0d: no ack or nak within %0d cycles of the request",
                 test_num, RESP_LIMIT);
        test_ok = 1'b0;
      end else begin
        if (latency != RESP_LATENCY) begin
          $display("test %0d: response came %0d cycles after the request, expected %0d",
                   test_num, latency, RESP_LATENCY);
          test_ok = 1'b0;
        end
        if (ack !== exp_ack) begin
          $display("Mismatch test %0d: ack expected %h actual %h", test_num, exp_ack, ack);
          test_ok = 1'b0;
        end
        if (nak !== !exp_ack) begin
          $display("Mismatch test %0d: nak expected %h actual %h", test_num, !exp_ack, nak);
          test_ok = 1'b0;
        end
        // learn answers carry no checked result
        if (!req.source && result !== exp_result) begin
          $display("Mismatch test %0d: result expected %h actual %h",
                   test_num, exp_result, result);
          test_ok = 1'b0;
        end
        @(negedge clk);
        if (ack !== 1'b0 || nak !== 1'b0) begin
          $display("test %0d: response strobe lasted more than one cycle", test_num);
          test_ok = 1'b0;
        end
        // ready is back one cycle after the response
        if (latency == RESP_LATENCY && ready !== 1'b1) begin
          $display("Mismatch test %0d: ready expected %h actual %h", test_num, 1'b1, ready);
          test_ok = 1'b0;
        end
        if (!req.source && result !== exp_result) begin
          $display("Mismatch test %0d: held result expected %h actual %h",
                   test_num, exp_result, result);
          test_ok = 1'b0;
        end
      end

      if (test_ok) begin
        pass_count++;
      end else begin
        fail_count++;
      end
      $display("test %0d %s index %h: %s", test_num, req.source ? "learn" : "lookup",
               req.index, test_ok ? "ok" : "failed");
    end

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== tb/mac_table_golden.txt ====
// test source index mac portmap exp_ack exp_result, all hex
// source 1 = learn, 0 = lookup; result column unused on learn lines
// empty table after flush
01 0 05a 0123456789ab 0001 0 fffe
02 0 000 000000000000 0000 0 ffff
03 0 3ff ffffffffffff 8000 0 7fff
// learn into an empty bucket, lands in way 0
04 1 05a 0123456789ab 0004 1 0000
05 0 05a 0123456789ab 0001 1 0004
// second mac in the same bucket goes to way 1
06 1 05a 0123456789ac 0010 1 0000
07 0 05a 0123456789ab 0001 1 0004
08 0 05a 0123456789ac 0002 1 0010
// full bucket
09 1 05a a1b2c3d4e5f6 0100 0 0000
0a 0 05a a1b2c3d4e5f6 0100 0 feff
0b 0 05a 0123456789ab 0001 1 0004
0c 0 05a 0123456789ac 0002 1 0010
// only one 24-bit half matches
0d 0 05a ffffff6789ab 0001 0 fffe
0e 0 05a 012345ffffff 0003 0 fffc
// refresh in place in a full bucket
0f 1 05a 0123456789ab 0800 1 0000
10 0 05a 0123456789ab 0001 1 0800
11 0 05a 0123456789ac 0002 1 0010
12 1 05a 0123456789ac 0200 1 0000
13 0 05a 0123456789ac 0002 1 0200
14 0 05a 0123456789ab 0001 1 0800
// bucket isolation
15 1 200 5e0000abcdef 0020 1 0000
16 0 201 5e0000abcdef 0020 0 ffdf
17 0 1ff 5e0000abcdef 0040 0 ffbf
18 0 200 5e0000abcdef 0040 1 0020
19 0 05b 0123456789ab 0001 0 fffe
// same mac learned in a second bucket
1a 1 3ff 0123456789ab 4000 1 0000
1b 0 3ff 0123456789ab 0001 1 4000
1c 0 05a 0123456789ab 0001 1 0800
// fill the last bucket, then overflow it
1d 1 3ff 0000000000aa 0008 1 0000
1e 1 3ff 0000000000bb 0008 0 0000
1f 0 3ff 0000000000aa 0001 1 0008
20 0 3ff 0000000000bb 0f0f 0 f0f0

// ==== project.f ====
source/mac_table_pkg.sv
source/mac_table_ram.sv
source/mac_table_way.sv
source/mac_table_ctrl.sv
source/mac_table_top.sv
tb/mac_table_tb.sv

// ==== Bender.yml ====
package:
  name: mac_table

dependencies: {}

sources:
  # package first, then the RTL bottom up
  - files:
      - source/mac_table_pkg.sv
      - source/mac_table_ram.sv
      - source/mac_table_way.sv
      - source/mac_table_ctrl.sv
      - source/mac_table_top.sv

  # testbench, reads tb/mac_table_golden.txt at run time
  - target: test
    files:
      - tb/mac_table_tb.sv
